/* all.f */
src/pipePkg.sv
src/regFile.sv
src/forwardingUnit.sv
src/decodeStage.sv
src/executeStage.sv
src/bypassPipeTop.sv
dv/bypassPipeTb.sv

/* build.sh */
#!/bin/sh
# Build and run the bypass pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module bypassPipeTb -f all.f -o bypassPipeSim

# The simulator exit code is not trusted alone, the log decides
./obj_dir/bypassPipeSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

/* dv/bypassTestdata.txt */
# I op rd rs rt imm noGap : instruction in hex, noGap 1 forbids idle cycles before it
# W reg data : next expected writeback    B taken : next expected branch outcome
I 6 01 00 00 0005 0  W 01 00000005  # Basic ops, register values built with addi
I 6 02 00 00 0003 0  W 02 00000003
I 6 03 00 00 FFFE 0  W 03 FFFFFFFE  # Negative immediate
I 1 04 01 02 0000 0  W 04 00000008
I 2 05 02 01 0000 0  W 05 FFFFFFFE
I 3 06 01 03 0000 0  W 06 00000004
I 4 07 01 03 0000 0  W 07 FFFFFFFF
I 5 08 03 02 0000 0  W 08 00000001  # slt -2 < 3
I 5 09 02 03 0000 0  W 09 00000000  # slt 3 < -2
I 5 0A 03 07 0000 0  W 0A 00000001  # slt -2 < -1
I 2 0B 00 07 0000 0  W 0B 00000001  # 0 - 0xffffffff wraps
I 6 0D 00 00 0010 0  W 0D 00000010  # Forwarding at distance one and two
I 1 0E 0D 0D 0000 1  W 0E 00000020
I 2 0F 0E 0D 0000 1  W 0F 00000010
I 6 0F 0F 00 0007 1  W 0F 00000017
I 4 10 0E 0F 0000 1  W 10 00000037
I 6 11 00 00 0001 0  W 11 00000001  # Two writers, nearer one wins
I 6 11 00 00 0002 1  W 11 00000002
I 1 12 11 11 0000 1  W 12 00000004
I 6 00 00 00 0055 0  W 00 00000055  # Register zero writes are reported but dropped
I 1 13 00 00 0000 1  W 13 00000000
I 6 00 01 00 0100 1  W 00 00000105
I 6 14 00 00 0009 1  W 14 00000009
I 6 18 00 00 0200 0  W 18 00000200  # Distance three through the register file
I 6 19 00 00 0001 1  W 19 00000001
I 6 1A 00 00 0002 1  W 1A 00000002
I 2 1B 18 19 0000 1  W 1B 000001FF
I 6 1E 00 00 0005 0  W 1E 00000005  # Early branch
I 7 00 02 02 0000 0  B 1            # Register file operands
I 7 00 01 02 0000 0  B 0
I 6 1C 00 00 0005 0  W 1C 00000005
I 6 1D 00 00 0006 1  W 1D 00000006
I 7 00 1C 01 0000 1  B 1            # rs from EX/MEM
I 6 1E 00 00 0007 0  W 1E 00000007
I 0 00 00 00 0000 1
I 7 00 01 1E 0000 1  B 0            # rt from EX/MEM, stale value would match
I 6 1F 00 00 0003 0  W 1F 00000003
I 0 00 00 00 0000 1
I 0 00 00 00 0000 1
I 7 00 1F 02 0000 1  B 1            # Write-before-read bypass

/* dv/bypassPipeTb.sv */
`timescale 1ns/10ps
`default_nettype none

module bypassPipeTb import pipePkg::*;
();

	localparam int drainLimitP = 200;

	logic clk;
	logic arstN;
	logic instValid;
	instT inst;
	logic wbValid;
	wbT   wb;
	logic branchValid;
	logic branchTaken;

	// Records from the data file
	instT instList[$];
	bit   noGapList[$];
	wbT   wbExpect[$];
	bit   branchExpect[$];

	int seed;

	bypassPipeTop dut0 (.clk(clk), .arstN(arstN), .instValid(instValid), .inst(inst),
		.wbValid(wbValid), .wb(wb), .branchValid(branchValid), .branchTaken(branchTaken));

	// 40 ns period
	always #20 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and comparison
	//////////////////////////////////////////////////////////////////////

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			abortRun($sformatf("[FAIL] %0d ns: %s: got %h, expected %h", $time, what,
				actual, expected));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test data parser
	//////////////////////////////////////////////////////////////////////

	task automatic loadTestdata();
		int          fd;
		int          code;
		int          ch;
		logic [7:0]  kind;
		logic [31:0] f0, f1, f2, f3, f4, f5;
		instT        instRec;
		wbT          wbRec;
		fd = $fopen("dv/bypassTestdata.txt", "r");
		if (fd == 0)
			abortRun("Could not open the test data file dv/bypassTestdata.txt");
		code = $fscanf(fd, " %c", kind);
		while (code == 1)
		begin
			case (kind)
				"#":
				begin
					// Comment runs to end of line
					ch = $fgetc(fd);
					while (ch != 10 && ch != -1)
						ch = $fgetc(fd);
				end
				"I":
				begin
					code = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
					if (code != 6)
						abortRun("Malformed instruction record in the test data");
					instRec.op  = opT'(f0[3:0]);
					instRec.rd  = f1[4:0];
					instRec.rs  = f2[4:0];
					instRec.rt  = f3[4:0];
					instRec.imm = f4[15:0];
					instList.push_back(instRec);
					noGapList.push_back(f5[0]);
				end
				"W":
				begin
					code = $fscanf(fd, "%h %h", f0, f1);
					if (code != 2)
						abortRun("Malformed writeback record in the test data");
					wbRec.regIdx = f0[4:0];
					wbRec.data   = f1;
					wbExpect.push_back(wbRec);
				end
				"B":
				begin
					code = $fscanf(fd, "%h", f0);
					if (code != 1)
						abortRun("Malformed branch record in the test data");
					branchExpect.push_back(f0[0]);
				end
				default:
					abortRun("Unknown record kind in the test data");
			endcase
			code = $fscanf(fd, " %c", kind);
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Result monitor
	//////////////////////////////////////////////////////////////////////

	// Mid-cycle sampling, outputs are registered
	always @(negedge clk)
	begin
		if (!arstN)
		begin
			checkEqual({31'd0, wbValid}, 32'd0, "writeback strobe during reset");
			checkEqual({31'd0, branchValid}, 32'd0, "branch strobe during reset");
		end
		else
		begin
			if (wbValid)
			begin
				if (wbExpect.size() == 0)
					abortRun("A writeback arrived when none was expected");
				checkEqual({27'd0, wb.regIdx}, {27'd0, wbExpect[0].regIdx}, "writeback reg");
				checkEqual(wb.data, wbExpect[0].data, "writeback data");
				void'(wbExpect.pop_front());
			end
			if (branchValid)
			begin
				if (branchExpect.size() == 0)
					abortRun("A branch outcome arrived when none was expected");
				checkEqual({31'd0, branchTaken}, {31'd0, branchExpect[0]}, "branch taken");
				void'(branchExpect.pop_front());
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int gap;
		int waitCycles;
		clk       = 1'b0;
		arstN     = 1'b1;
		instValid = 1'b0;
		inst      = '0;
		seed      = 79618;
		loadTestdata();
		// Real falling edge on reset, then 8 cycles low
		#2 arstN = 1'b0;
		repeat (8) @(posedge clk);
		#2 arstN = 1'b1;
		foreach (instList[i])
		begin
			// Random 0 to 2 idle cycles unless the record forbids them
			if (!noGapList[i])
			begin
				gap = $unsigned($random(seed)) % 3;
				repeat (gap)
				begin
					@(posedge clk);
					#2 instValid = 1'b0;
				end
			end
			@(posedge clk);
			#2;
			instValid = 1'b1;
			inst      = instList[i];
		end
		@(posedge clk);
		#2 instValid = 1'b0;
		// Drain both queues
		waitCycles = 0;
		while ((wbExpect.size() != 0 || branchExpect.size() != 0) && waitCycles < drainLimitP)
		begin
			@(posedge clk);
			waitCycles++;
		end
		if (wbExpect.size() != 0 || branchExpect.size() != 0)
			abortRun("Timed out after 200 cycles waiting for the expected results");
		// A few quiet cycles catch stray strobes
		repeat (4) @(posedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* src/bypassPipeTop.sv */
`timescale 1ns/10ps
`default_nettype none

module bypassPipeTop import pipePkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  logic instValid,
	input  instT inst,
	output logic wbValid,
	output wbT   wb,
	output logic branchValid,
	output logic branchTaken
);

	idExT                  idEx;
	exMemT                 exMem;
	memWbT                 memWb;
	fwdSelT                fwdA;
	fwdSelT                fwdB;
	logic                  fwdBranchA;
	logic                  fwdBranchB;
	logic                  decBranch;
	regIdxT                rfIdxA;
	regIdxT                rfIdxB;
	logic [dataWidthP-1:0] rfDataA;
	logic [dataWidthP-1:0] rfDataB;

	// Writeback straight from MEM/WB
	assign wbValid = memWb.regWrite;
	assign wb      = '{regIdx: memWb.rd, data: memWb.result};

	regFile regFile0 (.clk(clk), .arstN(arstN), .rdIdxA(rfIdxA), .rdIdxB(rfIdxB),
		.rdDataA(rfDataA), .rdDataB(rfDataB), .wrEn(memWb.regWrite), .wrIdx(memWb.rd),
		.wrData(memWb.result));

	forwardingUnit forwardingUnit0 (.idEx(idEx), .exMem(exMem), .memWb(memWb),
		.decRs(rfIdxA), .decRt(rfIdxB), .decBranch(decBranch), .fwdA(fwdA), .fwdB(fwdB),
		.fwdBranchA(fwdBranchA), .fwdBranchB(fwdBranchB));

	decodeStage decodeStage0 (.clk(clk), .arstN(arstN), .instValid(instValid),
		.inst(inst), .rfDataA(rfDataA), .rfDataB(rfDataB), .rfIdxA(rfIdxA),
		.rfIdxB(rfIdxB), .fwdBranchA(fwdBranchA), .fwdBranchB(fwdBranchB),
		.exMem(exMem), .decBranch(decBranch), .idEx(idEx), .branchValid(branchValid),
		.branchTaken(branchTaken));

	executeStage executeStage0 (.clk(clk), .arstN(arstN), .idEx(idEx), .fwdA(fwdA),
		.fwdB(fwdB), .exMem(exMem), .memWb(memWb));

endmodule

`default_nettype wire

/* src/executeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module executeStage import pipePkg::*;
(
	input  logic   clk,
	input  logic   arstN,
	input  idExT   idEx,
	input  fwdSelT fwdA,
	input  fwdSelT fwdB,
	output exMemT  exMem,
	output memWbT  memWb
);

	exMemT                 exPayQ;
	memWbT                 wbPayQ;

	logic [dataWidthP-1:0] immExt;
	logic [dataWidthP-1:0] rtFwd;
	logic [dataWidthP-1:0] opA;
	logic [dataWidthP-1:0] opB;
	logic [dataWidthP-1:0] aluRes;

	//////////////////////////////////////////////////////////////////////
	// Operand selection
	//////////////////////////////////////////////////////////////////////

	// Pick the operand source
	function automatic logic [dataWidthP-1:0] fwdMux(
		fwdSelT                sel,
		logic [dataWidthP-1:0] rfData
	);
		logic [dataWidthP-1:0] value;
		case (sel)
			fwdExMem: value = exMem.result;
			fwdMemWb: value = memWb.result;
			default:  value = rfData;
		endcase
		return value;
	endfunction

	assign immExt = {{(dataWidthP-immWidthP){idEx.imm[immWidthP-1]}}, idEx.imm};

	always_comb
	begin
		opA   = fwdMux(fwdA, idEx.rsData);
		rtFwd = fwdMux(fwdB, idEx.rtData);
	end

	// Immediate replaces rt for addi
	assign opB   = (idEx.op == opAddi) ? immExt : rtFwd;

	//////////////////////////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (idEx.op)
			opAdd, opAddi: aluRes = opA + opB;
			opSub:         aluRes = opA - opB;
			opAnd:         aluRes = opA & opB;
			opOr:          aluRes = opA | opB;
			// Signed compare
			opSlt:         aluRes = ($signed(opA) < $signed(opB)) ? dataWidthP'(1) : '0;
			default:       aluRes = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// EX/MEM and MEM/WB registers
	//////////////////////////////////////////////////////////////////////

	// Payload only moves with a valid stage, a bubble clears valid
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			exPayQ <= '0;
			wbPayQ <= '0;
		end
		else
		begin
			if (idEx.valid)
				exPayQ <= '{valid: 1'b1, rd: idEx.rd, regWrite: idEx.regWrite,
					result: aluRes};
			else
				exPayQ.valid <= 1'b0;
			// No data memory, MEM just passes along
			if (exMem.valid)
				wbPayQ <= '{valid: 1'b1, rd: exMem.rd, regWrite: exMem.regWrite,
					result: exMem.result};
			else
				wbPayQ.valid <= 1'b0;
		end
	end

	// Write enables qualified by stage valid
	always_comb
	begin
		exMem          = exPayQ;
		exMem.regWrite = exPayQ.regWrite && exPayQ.valid;
		memWb          = wbPayQ;
		memWb.regWrite = wbPayQ.regWrite && wbPayQ.valid;
	end

endmodule

`default_nettype wire

/* src/decodeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeStage import pipePkg::*;
(
	input  logic                  clk,
	input  logic                  arstN,
	input  logic                  instValid,
	input  instT                  inst,
	input  logic [dataWidthP-1:0] rfDataA,
	input  logic [dataWidthP-1:0] rfDataB,
	output regIdxT                rfIdxA,
	output regIdxT                rfIdxB,
	input  logic                  fwdBranchA,
	input  logic                  fwdBranchB,
	input  exMemT                 exMem,
	output logic                  decBranch,
	output idExT                  idEx,
	output logic                  branchValid,
	output logic                  branchTaken
);

	// ID/EX register
	idExT idPayQ;

	logic                  regWriteD;
	logic [dataWidthP-1:0] cmpA;
	logic [dataWidthP-1:0] cmpB;

	//////////////////////////////////////////////////////////////////////
	// Operand read and early branch
	//////////////////////////////////////////////////////////////////////

	assign rfIdxA = inst.rs;
	assign rfIdxB = inst.rt;

	assign decBranch = instValid && (inst.op == opBeq);

	// Everything but nop and beq writes rd
	always_comb
	begin
		case (inst.op)
			opNop, opBeq: regWriteD = 1'b0;
			default:      regWriteD = 1'b1;
		endcase
	end

	// Producer two ahead sits in EX/MEM
	assign cmpA = fwdBranchA ? exMem.result : rfDataA;
	assign cmpB = fwdBranchB ? exMem.result : rfDataB;

	//////////////////////////////////////////////////////////////////////
	// ID/EX register
	//////////////////////////////////////////////////////////////////////

	// Payload only moves with an instruction
	// Idle cycle loads a bubble
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			idPayQ <= '0;
		end
		else if (instValid)
		begin
			idPayQ.valid    <= 1'b1;
			idPayQ.op       <= inst.op;
			idPayQ.rd       <= inst.rd;
			idPayQ.rs       <= inst.rs;
			idPayQ.rt       <= inst.rt;
			idPayQ.rsData   <= rfDataA;
			idPayQ.rtData   <= rfDataB;
			idPayQ.imm      <= inst.imm;
			idPayQ.regWrite <= regWriteD;
		end
		else
		begin
			idPayQ.valid <= 1'b0;
		end
	end

	// Stale payload never looks like a live write
	always_comb
	begin
		idEx          = idPayQ;
		idEx.regWrite = idPayQ.regWrite && idPayQ.valid;
	end

	//////////////////////////////////////////////////////////////////////
	// Branch outcome
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			branchValid <= 1'b0;
			branchTaken <= 1'b0;
		end
		else
		begin
			branchValid <= decBranch;
			// Equal compare
			branchTaken <= decBranch && (cmpA == cmpB);
		end
	end

endmodule

`default_nettype wire

/* src/forwardingUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module forwardingUnit import pipePkg::*;
(
	input  idExT   idEx,
	input  exMemT  exMem,
	input  memWbT  memWb,
	input  regIdxT decRs,
	input  regIdxT decRt,
	input  logic   decBranch,
	output fwdSelT fwdA,
	output fwdSelT fwdB,
	output logic   fwdBranchA,
	output logic   fwdBranchB
);

	//////////////////////////////////////////////////////////////////////
	// Producer match helpers
	//////////////////////////////////////////////////////////////////////

	// EX/MEM holds a live write to srcReg
	function automatic logic exMemHit(regIdxT srcReg);
		return exMem.valid && exMem.regWrite
			&& (exMem.rd != '0) && (exMem.rd == srcReg);
	endfunction

	// MEM/WB holds a live write to srcReg
	function automatic logic memWbHit(regIdxT srcReg);
		return memWb.valid && memWb.regWrite
			&& (memWb.rd != '0) && (memWb.rd == srcReg);
	endfunction

	// Nearest producer first
	function automatic fwdSelT pickSource(regIdxT srcReg);
		fwdSelT sel;
		if (exMemHit(srcReg))
			sel = fwdExMem;
		else if (memWbHit(srcReg))
			sel = fwdMemWb;
		else
			sel = fwdNone;
		return sel;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Execute operands
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Bubble in execute takes register file data
		fwdA = fwdNone;
		fwdB = fwdNone;
		if (idEx.valid)
		begin
			// rs feeds the top ALU input
			fwdA = pickSource(idEx.rs);
			// rt feeds the bottom ALU input
			fwdB = pickSource(idEx.rt);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Decode branch compare
	//////////////////////////////////////////////////////////////////////

	// Only EX/MEM is forwarded here
	// MEM/WB reaches decode through the register file bypass
	always_comb
	begin
		fwdBranchA = decBranch && exMemHit(decRs);
		fwdBranchB = decBranch && exMemHit(decRt);
	end

endmodule

`default_nettype wire

/* src/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile import pipePkg::*;
(
	input  logic                  clk,
	input  logic                  arstN,
	input  regIdxT                rdIdxA,
	input  regIdxT                rdIdxB,
	output logic [dataWidthP-1:0] rdDataA,
	output logic [dataWidthP-1:0] rdDataB,
	input  logic                  wrEn,
	input  regIdxT                wrIdx,
	input  logic [dataWidthP-1:0] wrData
);

	// Register zero is not stored
	logic [dataWidthP-1:0] regsQ [1:regCountP-1];

	// Zero register, then bypass of the write in progress, then storage
	function automatic logic [dataWidthP-1:0] readPort(regIdxT idx);
		logic [dataWidthP-1:0] value;
		if (idx == '0)
			value = '0;
		else if (wrEn && (wrIdx == idx))
			value = wrData;
		else
			value = regsQ[idx];
		return value;
	endfunction

	always_comb
	begin
		rdDataA = readPort(rdIdxA);
		rdDataB = readPort(rdIdxB);
	end

	// Writes to register zero are dropped
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 1; i < regCountP; i++)
				regsQ[i] <= '0;
		end
		else if (wrEn && (wrIdx != '0))
		begin
			regsQ[wrIdx] <= wrData;
		end
	end

endmodule

`default_nettype wire

/* src/pipePkg.sv */
`default_nettype none

package pipePkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes fixed by the instruction format
	//////////////////////////////////////////////////////////////////////

	parameter int dataWidthP   = 32;
	parameter int regCountP    = 32;
	parameter int regIdxWidthP = 5;
	parameter int immWidthP    = 16;

	typedef logic [regIdxWidthP-1:0] regIdxT;

	// Operation codes as delivered by the decoder
	typedef enum logic [3:0] {
		opNop  = 4'd0,
		opAdd  = 4'd1,
		opSub  = 4'd2,
		opAnd  = 4'd3,
		opOr   = 4'd4,
		opSlt  = 4'd5,
		opAddi = 4'd6,
		opBeq  = 4'd7
	} opT;

	// Execute operand source, same codes as the classic forwarding unit
	typedef enum logic [1:0] {
		fwdNone  = 2'b00,
		fwdMemWb = 2'b01,
		fwdExMem = 2'b10
	} fwdSelT;

	//////////////////////////////////////////////////////////////////////
	// Stage payloads
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		opT                   op;
		regIdxT               rd;
		regIdxT               rs;
		regIdxT               rt;
		logic [immWidthP-1:0] imm;
	} instT;

	typedef struct packed {
		logic                  valid;
		opT                    op;
		regIdxT                rd;
		regIdxT                rs;
		regIdxT                rt;
		logic [dataWidthP-1:0] rsData;
		logic [dataWidthP-1:0] rtData;
		logic [immWidthP-1:0]  imm;
		logic                  regWrite;
	} idExT;

	typedef struct packed {
		logic                  valid;
		regIdxT                rd;
		logic                  regWrite;
		logic [dataWidthP-1:0] result;
	} exMemT;

	// Same layout, later stage
	typedef struct packed {
		logic                  valid;
		regIdxT                rd;
		logic                  regWrite;
		logic [dataWidthP-1:0] result;
	} memWbT;

	// Writeback report
	typedef struct packed {
		regIdxT                regIdx;
		logic [dataWidthP-1:0] data;
	} wbT;

endpackage

`default_nettype wire
